//--- rtl/sram_pkg.sv
//----------------------------------------------------------
// SRAM word, address and matrix dimension types, with the
// layout of the dimension header in word 0
//----------------------------------------------------------
package sram_pkg;

  // Widths fixed by the SRAM macros and the header format
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int DIM_W  = 16;

  typedef logic [ADDR_W-1:0] sram_addr_t;

  // One SRAM word, also wide enough for the running dot product
  typedef logic [DATA_W-1:0] sram_data_t;

  // One matrix dimension from the header
  typedef logic [DIM_W-1:0]  dim_t;

  //----------------------------------------------------------
  // Header word: rows in the upper half, columns in the lower
  //----------------------------------------------------------
  localparam int DIM_ROWS_MSB = 31;
  localparam int DIM_COLS_MSB = 15;

  // Matrix data begins right after the header
  localparam sram_addr_t HEADER_WORDS = 12'd1;

endpackage

//--- rtl/qkv_pkg.sv
//----------------------------------------------------------
// Sequencing types for the Q/K/V projection engine
//----------------------------------------------------------
package qkv_pkg;

  //----------------------------------------------------------
  // Controller states
  //----------------------------------------------------------
  // IDLE       waiting for dut_valid, header address on the bus
  // LOAD_DIMS  header words returned, dimensions captured
  // ISSUE      one read pair per dot-product term
  // DRAIN      last returned pair accumulated
  // WRITE      one result word written
  // DONE       single cycle before dut_ready returns
  typedef enum logic [2:0] {
    IDLE,
    LOAD_DIMS,
    ISSUE,
    DRAIN,
    WRITE,
    DONE
  } ctrl_state_t;

  // Weight matrix in progress, 0 for Q, 1 for K, 2 for V
  typedef logic [1:0] mat_idx_t;

endpackage

//--- rtl/qkv_ctrl.sv
//----------------------------------------------------------
// Sequencing FSM, start handshake and MAC enable alignment
//----------------------------------------------------------
`timescale 1ns/1ps

module qkv_ctrl #(
  parameter int NUM_WEIGHTS = 3
) (
  input  logic clk,
  input  logic reset_n,
  input  logic dut_valid,
  input  logic k_last,
  input  logic elem_last,
  input  logic mat_last,
  output logic dut_ready,
  output logic dims_load,
  output logic step,
  output logic advance,
  output logic acc_en,
  output logic acc_first,
  output logic result_write_enable
);

  import qkv_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;

  // Next issued term starts a new dot product
  logic        first_pending;

  // Matrices finished in this run, cross-checks mat_last
  mat_idx_t    mat_cnt;

  //----------------------------------------------------------
  // State register and transitions
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (dut_valid) begin
          state_next = LOAD_DIMS;
        end
      end
      LOAD_DIMS: state_next = ISSUE;
      ISSUE: begin
        if (k_last) begin
          state_next = DRAIN;
        end
      end
      DRAIN: state_next = WRITE;
      WRITE: begin
        if (elem_last && mat_last) begin
          state_next = DONE;
        end else begin
          state_next = ISSUE;
        end
      end
      DONE: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // Decoded controls
  assign dut_ready           = (state == IDLE);
  assign dims_load           = (state == LOAD_DIMS);
  assign step                = (state == ISSUE);
  assign advance             = (state == WRITE);
  assign result_write_enable = (state == WRITE);

  //----------------------------------------------------------
  // MAC controls, one cycle behind the read addresses
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      first_pending <= 1'b0;
      acc_en        <= 1'b0;
      acc_first     <= 1'b0;
    end else begin
      acc_en    <= step;
      acc_first <= step && first_pending;
      if (dims_load || advance) begin
        first_pending <= 1'b1;
      end else if (step) begin
        first_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mat_cnt <= '0;
    end else if (dims_load) begin
      mat_cnt <= '0;
    end else if (advance && elem_last) begin
      mat_cnt <= mat_cnt + 1'b1;
    end
  end

  // Accepted start drops ready on the next cycle
  a_start_drops_ready: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |=> !dut_ready);

  // Address generator agrees on which matrix is the last one
  a_mat_last_count: assert property (@(posedge clk) disable iff (!reset_n)
    (advance && elem_last) |-> mat_last == (mat_cnt == mat_idx_t'(NUM_WEIGHTS - 1)));

endmodule

//--- rtl/qkv_addr_gen.sv
//----------------------------------------------------------
// Dimension capture, loop counters and SRAM addresses for
// the row-major input, column-major weights and results
//----------------------------------------------------------
`timescale 1ns/1ps

module qkv_addr_gen #(
  parameter int NUM_WEIGHTS = 3
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 dims_load,
  input  logic                 step,
  input  logic                 advance,
  input  sram_pkg::sram_data_t input_read_data,
  input  sram_pkg::sram_data_t weight_read_data,
  output sram_pkg::sram_addr_t input_read_address,
  output sram_pkg::sram_addr_t weight_read_address,
  output sram_pkg::sram_addr_t result_write_address,
  output logic                 k_last,
  output logic                 elem_last,
  output logic                 mat_last
);

  import sram_pkg::*;
  import qkv_pkg::*;

  // Captured dimensions, I is rows x cols, W is w_rows x bcols
  dim_t       rows;
  dim_t       cols;
  dim_t       w_rows;
  dim_t       bcols;

  // Loop counters
  dim_t       k;
  dim_t       col;
  dim_t       row;
  mat_idx_t   mat;

  // First word of the current input row and weight matrix
  sram_addr_t in_row_base;
  sram_addr_t w_mat_base;

  logic       col_last;
  logic       row_last;

  assign k_last    = (k == cols - 1'b1);
  assign col_last  = (col == bcols - 1'b1);
  assign row_last  = (row == rows - 1'b1);
  assign elem_last = col_last && row_last;
  assign mat_last  = (mat == mat_idx_t'(NUM_WEIGHTS - 1));

  //----------------------------------------------------------
  // Header capture
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rows   <= '0;
      cols   <= '0;
      w_rows <= '0;
      bcols  <= '0;
    end else if (dims_load) begin
      rows   <= input_read_data[DIM_ROWS_MSB -: DIM_W];
      cols   <= input_read_data[DIM_COLS_MSB -: DIM_W];
      w_rows <= weight_read_data[DIM_ROWS_MSB -: DIM_W];
      bcols  <= weight_read_data[DIM_COLS_MSB -: DIM_W];
    end
  end

  //----------------------------------------------------------
  // Counters and addresses
  //----------------------------------------------------------
  // Both operands are contiguous in k, so each step just bumps
  // the addresses. After the last term the weight address has
  // already reached the next column, and the input address the
  // next row. Q, K and V are packed back to back row-major, so
  // the result address simply counts writes.
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      k                    <= '0;
      col                  <= '0;
      row                  <= '0;
      mat                  <= '0;
      in_row_base          <= '0;
      w_mat_base           <= '0;
      input_read_address   <= '0;
      weight_read_address  <= '0;
      result_write_address <= '0;
    end else if (dims_load) begin
      k                    <= '0;
      col                  <= '0;
      row                  <= '0;
      mat                  <= '0;
      in_row_base          <= HEADER_WORDS;
      w_mat_base           <= HEADER_WORDS;
      input_read_address   <= HEADER_WORDS;
      weight_read_address  <= HEADER_WORDS;
      result_write_address <= '0;
    end else if (step) begin
      k                   <= k + 1'b1;
      input_read_address  <= input_read_address + 1'b1;
      weight_read_address <= weight_read_address + 1'b1;
    end else if (advance) begin
      k                    <= '0;
      result_write_address <= result_write_address + 1'b1;
      if (!col_last) begin
        // Same input row again, next weight column
        col                <= col + 1'b1;
        input_read_address <= in_row_base;
      end else if (!row_last) begin
        // Next input row, back to the first weight column
        col                 <= '0;
        row                 <= row + 1'b1;
        in_row_base         <= input_read_address;
        weight_read_address <= w_mat_base;
      end else if (!mat_last) begin
        // Next weight matrix starts where this one ended
        col                <= '0;
        row                <= '0;
        mat                <= mat + 1'b1;
        in_row_base        <= HEADER_WORDS;
        input_read_address <= HEADER_WORDS;
        w_mat_base         <= weight_read_address;
      end else begin
        // Run complete, park on the header words
        col                  <= '0;
        row                  <= '0;
        mat                  <= '0;
        in_row_base          <= '0;
        w_mat_base           <= '0;
        input_read_address   <= '0;
        weight_read_address  <= '0;
        result_write_address <= '0;
      end
    end
  end

  // Header must describe a product that can be formed
  a_dims_valid: assert property (@(posedge clk) disable iff (!reset_n)
    dims_load |=> rows != '0 && cols != '0 && bcols != '0 && cols == w_rows);

endmodule

//--- rtl/qkv_mac.sv
//----------------------------------------------------------
// Multiply-accumulate on the returning SRAM words, modulo
// 2^32, with the running sum as result write data
//----------------------------------------------------------
`timescale 1ns/1ps

module qkv_mac (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 acc_en,
  input  logic                 acc_first,
  input  sram_pkg::sram_data_t input_read_data,
  input  sram_pkg::sram_data_t weight_read_data,
  output sram_pkg::sram_data_t result_write_data
);

  import sram_pkg::*;

  sram_data_t product;
  sram_data_t acc;

  // Low 32 bits of the product are all the modulo sum needs
  assign product = input_read_data * weight_read_data;

  //----------------------------------------------------------
  // Accumulator
  //----------------------------------------------------------
  // First term of a dot product replaces the old sum, later
  // terms add to it. The sum holds between elements so the
  // WRITE cycle sees the finished value.
  always_ff @(posedge clk) begin
    if (acc_en) begin
      if (acc_first) begin
        acc <= product;
      end else begin
        acc <= acc + product;
      end
    end
  end

  assign result_write_data = acc;

  // Controller only flags a first term on an accumulate cycle
  a_first_needs_en: assert property (@(posedge clk) disable iff (!reset_n)
    acc_first |-> acc_en);

endmodule

//--- rtl/qkv_top.sv
//----------------------------------------------------------
// Q/K/V projection engine, computes I x W for each weight
// matrix and stores the products in the result SRAM
//----------------------------------------------------------
`timescale 1ns/1ps

module qkv_top #(
  parameter int NUM_WEIGHTS = 3
) (
  input  logic                 clk,
  input  logic                 reset_n,

  // Start handshake
  input  logic                 dut_valid,
  output logic                 dut_ready,

  // Input SRAM read port
  output sram_pkg::sram_addr_t input_read_address,
  input  sram_pkg::sram_data_t input_read_data,

  // Weight SRAM read port
  output sram_pkg::sram_addr_t weight_read_address,
  input  sram_pkg::sram_data_t weight_read_data,

  // Result SRAM write port
  output logic                 result_write_enable,
  output sram_pkg::sram_addr_t result_write_address,
  output sram_pkg::sram_data_t result_write_data
);

  // Controller to address generator
  logic dims_load;
  logic step;
  logic advance;
  logic k_last;
  logic elem_last;
  logic mat_last;

  // Controller to MAC
  logic acc_en;
  logic acc_first;

  qkv_ctrl #(
    .NUM_WEIGHTS (NUM_WEIGHTS)
  ) i_ctrl (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .k_last              (k_last),
    .elem_last           (elem_last),
    .mat_last            (mat_last),
    .dut_ready           (dut_ready),
    .dims_load           (dims_load),
    .step                (step),
    .advance             (advance),
    .acc_en              (acc_en),
    .acc_first           (acc_first),
    .result_write_enable (result_write_enable)
  );

  qkv_addr_gen #(
    .NUM_WEIGHTS (NUM_WEIGHTS)
  ) i_addr_gen (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dims_load            (dims_load),
    .step                 (step),
    .advance              (advance),
    .input_read_data      (input_read_data),
    .weight_read_data     (weight_read_data),
    .input_read_address   (input_read_address),
    .weight_read_address  (weight_read_address),
    .result_write_address (result_write_address),
    .k_last               (k_last),
    .elem_last            (elem_last),
    .mat_last             (mat_last)
  );

  qkv_mac i_mac (
    .clk               (clk),
    .reset_n           (reset_n),
    .acc_en            (acc_en),
    .acc_first         (acc_first),
    .input_read_data   (input_read_data),
    .weight_read_data  (weight_read_data),
    .result_write_data (result_write_data)
  );

endmodule

//--- bench/tb_sram_model.sv
//----------------------------------------------------------
// Behavioral input, weight and result SRAMs, reads return
// their word one cycle after the address
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_sram_model (
  input  logic                 clk,
  input  logic                 reset_n,

  // Input SRAM read port
  input  sram_pkg::sram_addr_t input_read_address,
  output sram_pkg::sram_data_t input_read_data,

  // Weight SRAM read port
  input  sram_pkg::sram_addr_t weight_read_address,
  output sram_pkg::sram_data_t weight_read_data,

  // Result SRAM write port
  input  logic                 result_write_enable,
  input  sram_pkg::sram_addr_t result_write_address,
  input  sram_pkg::sram_data_t result_write_data
);

  import sram_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  // Loaded and inspected by the testbench through hierarchy
  sram_data_t input_mem  [DEPTH];
  sram_data_t weight_mem [DEPTH];
  sram_data_t result_mem [DEPTH];

  //----------------------------------------------------------
  // Registered read ports
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      input_read_data  <= '0;
      weight_read_data <= '0;
    end else begin
      input_read_data  <= input_mem[input_read_address];
      weight_read_data <= weight_mem[weight_read_address];
    end
  end

  // Result words are only read back once a run is over
  always @(posedge clk) begin
    if (result_write_enable) begin
      result_mem[result_write_address] = result_write_data;
    end
  end

endmodule

//--- bench/tb_qkv.sv
//----------------------------------------------------------
// Testbench for the Q/K/V projection engine, table driven
// with a reference matrix product per case
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_qkv;

  import sram_pkg::*;

  localparam int NUM_WEIGHTS = 3;
  localparam int NUM_CASES   = 4;
  localparam int MEM_DEPTH   = 1 << ADDR_W;

  //----------------------------------------------------------
  // Test table
  //----------------------------------------------------------
  // Random selects full-range data, hold keeps dut_valid high
  // through the run, writes is the expected pulse count
  localparam int CASE_ROWS   [NUM_CASES] = '{1, 2, 4, 3};
  localparam int CASE_COLS   [NUM_CASES] = '{1, 3, 4, 5};
  localparam int CASE_BCOLS  [NUM_CASES] = '{1, 2, 4, 2};
  localparam bit CASE_RANDOM [NUM_CASES] = '{0, 0, 1, 1};
  localparam bit CASE_HOLD   [NUM_CASES] = '{0, 1, 0, 1};
  localparam int CASE_WRITES [NUM_CASES] = '{3, 12, 48, 18};

  logic       clk;
  logic       reset_n;
  logic       dut_valid;
  logic       dut_ready;
  sram_addr_t input_read_address;
  sram_addr_t weight_read_address;
  sram_addr_t result_write_address;
  sram_data_t input_read_data;
  sram_data_t weight_read_data;
  sram_data_t result_write_data;
  logic       result_write_enable;

  // Stimulus copies and reference products
  logic [31:0] a_val [8][8];
  logic [31:0] w_val [NUM_WEIGHTS][8][8];
  logic [31:0] exp_val [256];
  logic [31:0] rng_state;

  int errors;
  int checks;
  int case_errors;
  int failed_tests;
  int cycle_count;
  int cycle_limit;

  qkv_top #(
    .NUM_WEIGHTS (NUM_WEIGHTS)
  ) i_qkv_top (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  tb_sram_model i_sram_model (
    .clk                  (clk),
    .reset_n              (reset_n),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // Run limit from the per-element cost of every case
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, dut_ready never returned high", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
      case_errors++;
    end
  endtask

  //----------------------------------------------------------
  // Memory load and reference product
  //----------------------------------------------------------
  task automatic load_case(input int t);
    int          rows;
    int          cols;
    int          bcols;
    int          a;
    int          r;
    int          c;
    int          k;
    int          m;
    logic [31:0] hdr;
    logic [31:0] sum;
    rows  = CASE_ROWS[t];
    cols  = CASE_COLS[t];
    bcols = CASE_BCOLS[t];
    for (a = 0; a < MEM_DEPTH; a++) begin
      i_sram_model.input_mem[a]  = 32'h1100_0000 | 32'(a);
      i_sram_model.weight_mem[a] = 32'h2200_0000 | 32'(a);
      i_sram_model.result_mem[a] = 32'h3300_0000 | 32'(a);
    end
    hdr = '0;
    hdr[DIM_ROWS_MSB -: DIM_W] = rows[15:0];
    hdr[DIM_COLS_MSB -: DIM_W] = cols[15:0];
    i_sram_model.input_mem[0] = hdr;
    hdr[DIM_ROWS_MSB -: DIM_W] = cols[15:0];
    hdr[DIM_COLS_MSB -: DIM_W] = bcols[15:0];
    i_sram_model.weight_mem[0] = hdr;
    // I row-major
    for (r = 0; r < rows; r++) begin
      for (k = 0; k < cols; k++) begin
        rng_state = next_random(rng_state);
        a_val[r][k] = CASE_RANDOM[t] ? rng_state : (rng_state & 32'hf);
        i_sram_model.input_mem[int'(HEADER_WORDS) + r * cols + k] = a_val[r][k];
      end
    end
    // Each W column-major, packed back to back
    for (m = 0; m < NUM_WEIGHTS; m++) begin
      for (c = 0; c < bcols; c++) begin
        for (k = 0; k < cols; k++) begin
          rng_state = next_random(rng_state);
          w_val[m][k][c] = CASE_RANDOM[t] ? rng_state : (rng_state & 32'hf);
          a = int'(HEADER_WORDS) + m * cols * bcols + c * cols + k;
          i_sram_model.weight_mem[a] = w_val[m][k][c];
        end
      end
    end
    for (m = 0; m < NUM_WEIGHTS; m++) begin
      for (r = 0; r < rows; r++) begin
        for (c = 0; c < bcols; c++) begin
          sum = '0;
          for (k = 0; k < cols; k++) begin
            sum = sum + a_val[r][k] * w_val[m][k][c];
          end
          exp_val[m * rows * bcols + r * bcols + c] = sum;
        end
      end
    end
  endtask

  //----------------------------------------------------------
  // One run, write order tracked on every edge
  //----------------------------------------------------------
  task automatic run_case(input int t);
    int writes;
    bit done;
    writes = 0;
    done   = 1'b0;
    @(posedge clk);
    dut_valid <= 1'b1;
    @(posedge clk);
    if (!CASE_HOLD[t]) begin
      dut_valid <= 1'b0;
    end
    while (!done) begin
      @(posedge clk);
      if (result_write_enable) begin
        check_value("result_write_address", 32'(result_write_address), 32'(writes));
        writes++;
      end
      // Held start drops after the last write so no second run follows
      if (CASE_HOLD[t] && writes == CASE_WRITES[t]) begin
        dut_valid <= 1'b0;
      end
      if (dut_ready) begin
        done = 1'b1;
      end
    end
    check_value("write count", 32'(writes), 32'(CASE_WRITES[t]));
    repeat (2) begin
      @(posedge clk);
      check_value("dut_ready", 32'(dut_ready), 32'd1);
    end
  endtask

  task automatic compare_results(input int t);
    int    r;
    int    c;
    int    m;
    int    idx;
    string mat_name;
    for (m = 0; m < NUM_WEIGHTS; m++) begin
      mat_name = (m == 0) ? "Q" : ((m == 1) ? "K" : "V");
      for (r = 0; r < CASE_ROWS[t]; r++) begin
        for (c = 0; c < CASE_BCOLS[t]; c++) begin
          idx = m * CASE_ROWS[t] * CASE_BCOLS[t] + r * CASE_BCOLS[t] + c;
          check_value($sformatf("%s[%0d][%0d]", mat_name, r, c),
                      i_sram_model.result_mem[idx], exp_val[idx]);
        end
      end
    end
  endtask

  initial begin
    int t;
    rng_state    = 32'he81e7bce;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    cycle_count  = 0;
    cycle_limit  = 200;
    for (t = 0; t < NUM_CASES; t++) begin
      cycle_limit += 3 * CASE_ROWS[t] * CASE_BCOLS[t] * (CASE_COLS[t] + 2) + 10;
    end
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    // Idle outputs before any start
    case_errors = 0;
    check_value("dut_ready", 32'(dut_ready), 32'd1);
    check_value("result_write_enable", 32'(result_write_enable), 32'd0);
    if (case_errors != 0) begin
      failed_tests++;
    end
    $display("Reset state: %0d errors", case_errors);

    for (t = 0; t < NUM_CASES; t++) begin
      case_errors = 0;
      load_case(t);
      run_case(t);
      compare_results(t);
      if (case_errors != 0) begin
        failed_tests++;
      end
      $display("Case %0d (%0dx%0dx%0d, %s data%s): %0d errors", t, CASE_ROWS[t],
               CASE_COLS[t], CASE_BCOLS[t], CASE_RANDOM[t] ? "full-range" : "small",
               CASE_HOLD[t] ? ", dut_valid held" : "", case_errors);
    end

    $display("Tests %0d, failed tests %0d, checks %0d, errors %0d",
             NUM_CASES + 1, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/sram_pkg.sv
rtl/qkv_pkg.sv
rtl/qkv_ctrl.sv
rtl/qkv_addr_gen.sv
rtl/qkv_mac.sv
rtl/qkv_top.sv
bench/tb_sram_model.sv
bench/tb_qkv.sv

//--- run.sh
#!/bin/sh
# Build the Q/K/V testbench with Verilator, run it and judge
# the outcome from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_qkv -f compile.f -o tb_qkv \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_qkv > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log && { echo "PASS"; exit 0; }
echo "Simulation ended without a verdict, see sim.log" && exit 1
